// File: common/rv_config.svh
/* core-wide constants; opcode and funct3 values cover only the supported RV64I subset
   RESET_PC must be word aligned, fetch ignores the low 2 bits */
`ifndef RV_CONFIG_SVH
`define RV_CONFIG_SVH

// datapath width and register file size
`define XLEN          64
`define REG_NUM       32
`define RESET_PC      64'h0

// major opcodes, instruction bits 6:0
`define OPC_OP_IMM    7'b0010011
`define OPC_OP        7'b0110011
`define OPC_OP_IMM32  7'b0011011
`define OPC_LUI       7'b0110111
`define OPC_AUIPC     7'b0010111
`define OPC_JAL       7'b1101111
`define OPC_BRANCH    7'b1100011

// funct3 values, instruction bits 14:12
`define F3_ADDI       3'b000
`define F3_SLLI       3'b001
`define F3_ADD        3'b000
`define F3_ADDIW      3'b000
`define F3_BNE        3'b001

// funct7 for plain ADD (SUB sets bit 5)
`define F7_ADD        7'b0000000

`endif

// File: common/rv_pkg.sv
/* shared types of the core; widths follow XLEN from the config header */
`default_nettype none

package rv_pkg;
  `include "rv_config.svh"

  // I-type, also used for R-type (imm holds funct7 and rs2)
  typedef struct packed {
    logic [11:0] imm;
    logic [4:0]  rs1;
    logic [2:0]  funct3;
    logic [4:0]  rd;
    logic [6:0]  opcode;
  } i_fmt_s;

  // B-type, immediate scattered around the register fields
  typedef struct packed {
    logic        imm12;
    logic [5:0]  imm10_5;
    logic [4:0]  rs2;
    logic [4:0]  rs1;
    logic [2:0]  funct3;
    logic [3:0]  imm4_1;
    logic        imm11;
    logic [6:0]  opcode;
  } b_fmt_s;

  // J-type
  typedef struct packed {
    logic        imm20;
    logic [9:0]  imm10_1;
    logic        imm11;
    logic [7:0]  imm19_12;
    logic [4:0]  rd;
    logic [6:0]  opcode;
  } j_fmt_s;

  // U-type
  typedef struct packed {
    logic [19:0] imm31_12;
    logic [4:0]  rd;
    logic [6:0]  opcode;
  } u_fmt_s;

  // one instruction word, four views
  typedef union packed {
    i_fmt_s i_fmt;
    b_fmt_s b_fmt;
    j_fmt_s j_fmt;
    u_fmt_s u_fmt;
  } inst_u;

  typedef enum logic [3:0] {
    OP_NONE,
    OP_ADDI,
    OP_ADD,
    OP_ADDIW,
    OP_SLLI,
    OP_LUI,
    OP_AUIPC,
    OP_JAL,
    OP_BNE
  } exe_op_e;

  // decode to execute bundle
  typedef struct packed {
    logic               ena;
    exe_op_e            op;
    logic [4:0]         rd;
    logic [`XLEN-1:0]   op1;
    logic [`XLEN-1:0]   op2;
    logic [`XLEN-1:0]   t1;
    logic [`XLEN-1:0]   pc;
  } dec_s;

  // write-back report, also the register file write port
  typedef struct packed {
    logic               valid;
    logic [4:0]         rd;
    logic [`XLEN-1:0]   data;
  } wb_s;

endpackage

`default_nettype wire

// File: design/if_stage.sv
/* PC register; updates only on an accepted instruction, no misaligned target check */
`timescale 1ns/100ps
`default_nettype none

`include "rv_config.svh"

module if_stage (
  input  wire               i_clk,
  input  wire               i_rst_n,
  input  wire               i_adv,
  input  wire               i_jmp,
  input  wire [`XLEN-1:0]   i_jmp_addr,
  output logic [`XLEN-1:0]  o_pc
);

  logic [`XLEN-1:0] pc;
  logic [`XLEN-1:0] pc_next;

  // sequential fetch unless execute redirects
  always_comb begin
    if (i_jmp) begin
      pc_next = i_jmp_addr;
    end else begin
      pc_next = pc + `XLEN'd4;
    end
  end

  // hold while stalled
  always_ff @(posedge i_clk) begin
    if (!i_rst_n) begin
      pc <= `RESET_PC;
    end else if (i_adv) begin
      pc <= pc_next;
    end
  end

  assign o_pc = pc;

endmodule

`default_nettype wire

// File: design/id_stage.sv
/* combinational decode of the supported RV64I subset; anything else is illegal
   and leaves ena low, so the instruction has no effect beyond the PC step */
`timescale 1ns/100ps
`default_nettype none

`include "rv_config.svh"

module id_stage import rv_pkg::*; (
  input  wire [`XLEN-1:0]   i_pc,
  input  inst_u             i_inst,
  input  wire               i_inst_valid,
  input  wire [`XLEN-1:0]   i_rs1_data,
  input  wire [`XLEN-1:0]   i_rs2_data,
  output logic [4:0]        o_rs1_addr,
  output logic [4:0]        o_rs2_addr,
  output dec_s              o_dec
);

  exe_op_e          op;
  logic [6:0]       opcode;
  logic [2:0]       funct3;
  logic [`XLEN-1:0] imm_i;
  logic [`XLEN-1:0] imm_u;
  logic [`XLEN-1:0] imm_j;
  logic [`XLEN-1:0] imm_b;

  assign opcode = i_inst.i_fmt.opcode;
  assign funct3 = i_inst.i_fmt.funct3;

  // register fields sit at the same bits in every format
  assign o_rs1_addr = i_inst.i_fmt.rs1;
  assign o_rs2_addr = i_inst.b_fmt.rs2;

  // immediates, all sign extended to XLEN
  assign imm_i = {{(`XLEN-12){i_inst.i_fmt.imm[11]}}, i_inst.i_fmt.imm};
  assign imm_u = {{(`XLEN-32){i_inst.u_fmt.imm31_12[19]}}, i_inst.u_fmt.imm31_12, 12'b0};
  assign imm_j = {{(`XLEN-21){i_inst.j_fmt.imm20}}, i_inst.j_fmt.imm20,
                  i_inst.j_fmt.imm19_12, i_inst.j_fmt.imm11, i_inst.j_fmt.imm10_1, 1'b0};
  assign imm_b = {{(`XLEN-13){i_inst.b_fmt.imm12}}, i_inst.b_fmt.imm12,
                  i_inst.b_fmt.imm11, i_inst.b_fmt.imm10_5, i_inst.b_fmt.imm4_1, 1'b0};

  // opcode / funct3 legality
  always_comb begin
    op = OP_NONE;
    case (opcode)
      `OPC_OP_IMM: begin
        if (funct3 == `F3_ADDI) begin
          op = OP_ADDI;
        end else if (funct3 == `F3_SLLI && i_inst.i_fmt.imm[11:6] == 6'd0) begin
          // RV64 shamt is 6 bits, upper funct6 must be zero
          op = OP_SLLI;
        end
      end
      `OPC_OP: begin
        // funct7 lives in imm[11:5] of the I view
        if (funct3 == `F3_ADD && i_inst.i_fmt.imm[11:5] == `F7_ADD) begin
          op = OP_ADD;
        end
      end
      `OPC_OP_IMM32: begin
        if (funct3 == `F3_ADDIW) begin
          op = OP_ADDIW;
        end
      end
      `OPC_LUI:   op = OP_LUI;
      `OPC_AUIPC: op = OP_AUIPC;
      `OPC_JAL:   op = OP_JAL;
      `OPC_BRANCH: begin
        if (funct3 == `F3_BNE) begin
          op = OP_BNE;
        end
      end
      default: op = OP_NONE;
    endcase
  end

  // operand selection
  always_comb begin
    o_dec     = '0;
    o_dec.ena = (op != OP_NONE) && i_inst_valid;
    o_dec.op  = op;
    o_dec.pc  = i_pc;
    // branches have no rd, those bits are immediate
    o_dec.rd  = (op == OP_BNE) ? 5'd0 : i_inst.u_fmt.rd;
    case (op)
      OP_ADDI, OP_SLLI, OP_ADDIW: begin
        o_dec.op1 = i_rs1_data;
        o_dec.op2 = imm_i;
      end
      OP_ADD: begin
        o_dec.op1 = i_rs1_data;
        o_dec.op2 = i_rs2_data;
      end
      OP_LUI: o_dec.op1 = imm_u;
      OP_AUIPC: begin
        o_dec.op1 = i_pc;
        o_dec.op2 = imm_u;
      end
      OP_JAL: begin
        // link value and target
        o_dec.op1 = i_pc + `XLEN'd4;
        o_dec.t1  = i_pc + imm_j;
      end
      OP_BNE: begin
        o_dec.op1 = i_rs1_data;
        o_dec.op2 = i_rs2_data;
        o_dec.t1  = i_pc + imm_b;
      end
      default: o_dec.rd = 5'd0;
    endcase
  end

endmodule

`default_nettype wire

// File: design/regfile.sv
/* 31 writable registers, x0 reads zero; reads are combinational, writes land on the edge */
`timescale 1ns/100ps
`default_nettype none

`include "rv_config.svh"

module regfile import rv_pkg::*; (
  input  wire               i_clk,
  input  wire               i_rst_n,
  input  wire [4:0]         i_rs1_addr,
  input  wire [4:0]         i_rs2_addr,
  input  wb_s               i_wb,
  output logic [`XLEN-1:0]  o_rs1_data,
  output logic [`XLEN-1:0]  o_rs2_data
);

  // x0 has no storage
  logic [`XLEN-1:0] regs [1:`REG_NUM-1];

  always_ff @(posedge i_clk) begin
    if (!i_rst_n) begin
      for (int i = 1; i < `REG_NUM; i++) begin
        regs[i] <= '0;
      end
    end else if (i_wb.valid && i_wb.rd != 5'd0) begin
      regs[i_wb.rd] <= i_wb.data;
    end
  end

  // no bypass, the write is seen by the next instruction
  assign o_rs1_data = (i_rs1_addr == 5'd0) ? '0 : regs[i_rs1_addr];
  assign o_rs2_data = (i_rs2_addr == 5'd0) ? '0 : regs[i_rs2_addr];

endmodule

`default_nettype wire

// File: exu/exe_stage.sv
/* combinational execute; all outputs are zero while ena is low
   only JAL and BNE redirect the PC */
`timescale 1ns/100ps
`default_nettype none

`include "rv_config.svh"

module exe_stage import rv_pkg::*; (
  input  dec_s              i_dec,
  output logic              o_rd_wen,
  output logic [`XLEN-1:0]  o_rd_data,
  output logic              o_pc_jmp,
  output logic [`XLEN-1:0]  o_pc_jmpaddr
);

  logic [31:0] sum32;

  // word add for ADDIW, upper halves ignored
  assign sum32 = i_dec.op1[31:0] + i_dec.op2[31:0];

  // rd value
  always_comb begin
    o_rd_data = '0;
    if (i_dec.ena) begin
      case (i_dec.op)
        OP_ADDI, OP_ADD, OP_AUIPC: o_rd_data = i_dec.op1 + i_dec.op2;
        OP_ADDIW: o_rd_data = {{(`XLEN-32){sum32[31]}}, sum32};
        // full 6-bit shamt
        OP_SLLI: o_rd_data = i_dec.op1 << i_dec.op2[5:0];
        // op1 already holds U-imm or link address
        OP_LUI, OP_JAL: o_rd_data = i_dec.op1;
        default: o_rd_data = '0;
      endcase
    end
  end

  // write enable, never for x0 or branches
  always_comb begin
    o_rd_wen = 1'b0;
    if (i_dec.ena && i_dec.rd != 5'd0) begin
      case (i_dec.op)
        OP_BNE, OP_NONE: o_rd_wen = 1'b0;
        default: o_rd_wen = 1'b1;
      endcase
    end
  end

  // jump decision and target
  always_comb begin
    o_pc_jmp     = 1'b0;
    o_pc_jmpaddr = '0;
    if (i_dec.ena) begin
      case (i_dec.op)
        OP_BNE: begin
          o_pc_jmp     = (i_dec.op1 != i_dec.op2);
          o_pc_jmpaddr = i_dec.t1;
        end
        OP_JAL: begin
          o_pc_jmp     = 1'b1;
          o_pc_jmpaddr = i_dec.t1;
        end
        default: begin
          o_pc_jmp     = 1'b0;
          o_pc_jmpaddr = '0;
        end
      endcase
    end
  end

endmodule

`default_nettype wire

// File: design/rv_core.sv
/* single-cycle RV64I subset core; i_inst must be the word at o_pc in the same cycle
   i_inst_valid low stalls everything, there is no other handshake */
`timescale 1ns/100ps
`default_nettype none

`include "rv_config.svh"

module rv_core import rv_pkg::*; (
  input  wire               i_clk,
  input  wire               i_rst_n,
  input  wire [31:0]        i_inst,
  input  wire               i_inst_valid,
  output logic [`XLEN-1:0]  o_pc,
  output wb_s               o_wb
);

  inst_u            inst;
  dec_s             dec;
  logic [4:0]       rs1_addr;
  logic [4:0]       rs2_addr;
  logic [`XLEN-1:0] rs1_data;
  logic [`XLEN-1:0] rs2_data;
  logic             rd_wen;
  logic [`XLEN-1:0] rd_data;
  logic             pc_jmp;
  logic [`XLEN-1:0] pc_jmpaddr;

  assign inst = i_inst;

  // fetch, advances on every accepted word
  if_stage u_if (
    .i_clk      (i_clk),
    .i_rst_n    (i_rst_n),
    .i_adv      (i_inst_valid),
    .i_jmp      (pc_jmp),
    .i_jmp_addr (pc_jmpaddr),
    .o_pc       (o_pc)
  );

  id_stage u_id (
    .i_pc         (o_pc),
    .i_inst       (inst),
    .i_inst_valid (i_inst_valid),
    .i_rs1_data   (rs1_data),
    .i_rs2_data   (rs2_data),
    .o_rs1_addr   (rs1_addr),
    .o_rs2_addr   (rs2_addr),
    .o_dec        (dec)
  );

  // write port is the reported write-back
  regfile u_rf (
    .i_clk      (i_clk),
    .i_rst_n    (i_rst_n),
    .i_rs1_addr (rs1_addr),
    .i_rs2_addr (rs2_addr),
    .i_wb       (o_wb),
    .o_rs1_data (rs1_data),
    .o_rs2_data (rs2_data)
  );

  exe_stage u_exe (
    .i_dec        (dec),
    .o_rd_wen     (rd_wen),
    .o_rd_data    (rd_data),
    .o_pc_jmp     (pc_jmp),
    .o_pc_jmpaddr (pc_jmpaddr)
  );

  // nothing is reported while in reset
  assign o_wb = '{valid: rd_wen && i_rst_n, rd: dec.rd, data: rd_data};

endmodule

`default_nettype wire

// File: verif/rv_core_sva.sv
/* concurrent checks on the core boundary; reset, stall hold and x0 write-back
   reset must mask the write-back even while i_inst_valid is high */
`timescale 1ns/100ps
`default_nettype none

`include "rv_config.svh"

module rv_core_sva import rv_pkg::*; (
  input wire              i_clk,
  input wire              i_rst_n,
  input wire              i_inst_valid,
  input wire [`XLEN-1:0]  o_pc,
  input wb_s              o_wb
);

  // sync reset loads the start address
  a_reset_pc: assert property (@(posedge i_clk) !i_rst_n |=> o_pc == `RESET_PC)
    else $error("pc not at reset value after a reset cycle");

  a_reset_wb: assert property (@(posedge i_clk) !i_rst_n |-> !o_wb.valid)
    else $error("write-back reported during reset");

  // a stalled cycle freezes the PC
  a_stall_pc: assert property (@(posedge i_clk) disable iff (!i_rst_n)
    !i_inst_valid |=> $stable(o_pc))
    else $error("pc moved during a stall");

  a_stall_wb: assert property (@(posedge i_clk) !i_inst_valid |-> !o_wb.valid)
    else $error("write-back reported during a stall");

  // x0 never shows up as a destination
  a_no_x0: assert property (@(posedge i_clk) o_wb.valid |-> o_wb.rd != 5'd0)
    else $error("write-back targets x0");

endmodule

`default_nettype wire

// File: verif/tb_rv_core.sv
/* single-cycle core testbench; program image built at time zero, forward jumps only
   fetch is modelled combinationally from the shadow PC, stalls last one cycle */
`timescale 1ns/100ps
`default_nettype none

`include "rv_config.svh"

module tb_rv_core import rv_pkg::*; ();

  localparam int PROG_LEN    = 40;
  localparam int CYCLE_LIMIT = PROG_LEN * 2 + 20;

  logic             clk;
  logic             rst_n;
  logic [31:0]      inst;
  logic             inst_valid;
  logic [`XLEN-1:0] pc;
  wb_s              wb;
  logic [15:0]      lfsr;
  logic [31:0]      prog [0:PROG_LEN-1];
  logic [`XLEN-1:0] sregs [0:31];
  logic [`XLEN-1:0] spc;
  int               cycles;

  rv_core UUT (
    .i_clk        (clk),
    .i_rst_n      (rst_n),
    .i_inst       (inst),
    .i_inst_valid (inst_valid),
    .o_pc         (pc),
    .o_wb         (wb)
  );

  bind rv_core rv_core_sva u_sva (
    .i_clk        (i_clk),
    .i_rst_n      (i_rst_n),
    .i_inst_valid (i_inst_valid),
    .o_pc         (o_pc),
    .o_wb         (o_wb)
  );

  always #2 clk = ~clk;

  // run limit covers one stall per instruction
  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles >= CYCLE_LIMIT) begin
      $display("timeout: program did not finish within %0d cycles", CYCLE_LIMIT);
      $display("SIMULATION FAILED");
      $fatal(1, "run stopped by timeout");
    end
  end

  // galois lfsr, taps 16,14,13,11
  function automatic logic [15:0] lfsr_step(input logic [15:0] s);
    return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
  endfunction

  // one step per bit taken, lsb is the output bit
  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      v    = {v[30:0], lfsr[0]};
      lfsr = lfsr_step(lfsr);
    end
    return v;
  endfunction

  function automatic logic [31:0] enc_i(input logic [6:0] opc, input logic [2:0] f3,
                                        input logic [4:0] rd, input logic [4:0] rs1,
                                        input logic [11:0] imm);
    return {imm, rs1, f3, rd, opc};
  endfunction

  function automatic logic [31:0] enc_add(input logic [4:0] rd, input logic [4:0] rs1,
                                          input logic [4:0] rs2);
    return {`F7_ADD, rs2, rs1, `F3_ADD, rd, `OPC_OP};
  endfunction

  function automatic logic [31:0] enc_u(input logic [6:0] opc, input logic [4:0] rd,
                                        input logic [19:0] imm);
    return {imm, rd, opc};
  endfunction

  // offsets are byte offsets, bit 0 dropped
  function automatic logic [31:0] enc_jal(input logic [4:0] rd, input logic [20:0] off);
    return {off[20], off[10:1], off[11], off[19:12], rd, `OPC_JAL};
  endfunction

  function automatic logic [31:0] enc_bne(input logic [4:0] rs1, input logic [4:0] rs2,
                                          input logic [12:0] off);
    return {off[12], off[10:5], rs2, rs1, `F3_BNE, off[4:1], off[11], `OPC_BRANCH};
  endfunction

  // repeating 10-slot pattern, random regs and immediates
  task automatic build_program();
    logic [4:0]  rd;
    logic [4:0]  ra;
    logic [4:0]  rb;
    logic [19:0] imm;
    for (int k = 0; k < PROG_LEN; k++) begin
      rd  = 5'(rand_bits(5));
      ra  = 5'(rand_bits(5));
      rb  = 5'(rand_bits(5));
      imm = 20'(rand_bits(20));
      case (k % 10)
        0: prog[k] = enc_i(`OPC_OP_IMM, `F3_ADDI, rd, ra, imm[11:0]);
        1: prog[k] = enc_u(`OPC_LUI, rd, imm);
        2: prog[k] = enc_add(rd, ra, rb);
        3: prog[k] = enc_i(`OPC_OP_IMM32, `F3_ADDIW, rd, ra, imm[11:0]);
        4: prog[k] = enc_i(`OPC_OP_IMM, `F3_SLLI, rd, ra, {6'd0, imm[5:0]});
        5: prog[k] = enc_u(`OPC_AUIPC, rd, imm);
        // step 4 or skip one word
        6: prog[k] = enc_jal(rd, imm[0] ? 21'd8 : 21'd4);
        // equal operands half of the time
        7: prog[k] = enc_bne(ra, imm[1] ? ra : rb, 13'd8);
        8: prog[k] = enc_i(`OPC_OP_IMM, `F3_ADDI, 5'd0, ra, imm[11:0]);
        // load opcode, not supported
        default: prog[k] = {imm, rd, 7'b0000011};
      endcase
    end
  endtask

  // reference behaviour of one accepted word
  task automatic model_step(input logic [31:0] w, output logic wen, output logic [4:0] rd,
                            output logic [`XLEN-1:0] data, output logic [`XLEN-1:0] npc);
    logic [`XLEN-1:0] a;
    logic [`XLEN-1:0] b;
    logic [`XLEN-1:0] immi;
    logic [`XLEN-1:0] immu;
    logic [31:0]      s32;
    rd   = w[11:7];
    a    = sregs[w[19:15]];
    b    = sregs[w[24:20]];
    immi = {{52{w[31]}}, w[31:20]};
    immu = {{32{w[31]}}, w[31:12], 12'd0};
    wen  = 1'b0;
    data = '0;
    npc  = spc + 64'd4;
    case (w[6:0])
      `OPC_OP_IMM: begin
        wen  = (w[14:12] == 3'b000) || (w[14:12] == 3'b001 && w[31:26] == 6'd0);
        data = (w[14:12] == 3'b000) ? a + immi : a << w[25:20];
      end
      `OPC_OP: begin
        wen  = (w[14:12] == 3'b000) && (w[31:25] == 7'd0);
        data = a + b;
      end
      `OPC_OP_IMM32: begin
        s32  = a[31:0] + immi[31:0];
        wen  = (w[14:12] == 3'b000);
        data = {{32{s32[31]}}, s32};
      end
      `OPC_LUI: {wen, data} = {1'b1, immu};
      `OPC_AUIPC: {wen, data} = {1'b1, spc + immu};
      `OPC_JAL: begin
        {wen, data} = {1'b1, spc + 64'd4};
        npc = spc + {{43{w[31]}}, w[31], w[19:12], w[20], w[30:21], 1'b0};
      end
      `OPC_BRANCH: begin
        if (w[14:12] == 3'b001 && a != b) begin
          npc = spc + {{51{w[31]}}, w[31], w[7], w[30:25], w[11:8], 1'b0};
        end
      end
      default: wen = 1'b0;
    endcase
    // x0 never takes a write
    if (rd == 5'd0) begin
      wen = 1'b0;
    end
  endtask

  task automatic check_val(input string what, input logic [63:0] got, input logic [63:0] exp);
    assert (got === exp) else begin
      $display("ERR %0t: %s is %h, expected %h", $time, what, got, exp);
      $display("SIMULATION FAILED");
      $fatal(1, "value mismatch");
    end
  endtask

  initial begin
    logic             stall;
    logic             prev_stall;
    logic             exp_wen;
    logic [4:0]       exp_rd;
    logic [`XLEN-1:0] exp_data;
    logic [`XLEN-1:0] exp_npc;
    clk        = 1'b0;
    rst_n      = 1'b0;
    // a legal word offered during reset must not retire
    inst       = enc_u(`OPC_LUI, 5'd1, 20'h80001);
    inst_valid = 1'b1;
    cycles     = 0;
    lfsr       = 16'd41;
    prev_stall = 1'b0;
    for (int i = 0; i < 32; i++) begin
      sregs[i] = '0;
    end
    build_program();
    repeat (2) @(negedge clk);
    rst_n      = 1'b1;
    inst_valid = 1'b0;
    spc        = `RESET_PC;
    #1;
    check_val("pc after reset", pc, `RESET_PC);
    check_val("wb valid after reset", 64'(wb.valid), 64'd0);
    @(negedge clk);
    while (spc < PROG_LEN * 4) begin
      // single-cycle stall about a quarter of the time
      stall      = !prev_stall && (rand_bits(2) == 32'd0);
      inst       = prog[int'(spc >> 2)];
      inst_valid = !stall;
      #1;
      check_val("pc", pc, spc);
      if (stall) begin
        check_val("wb valid in stall", 64'(wb.valid), 64'd0);
      end else begin
        model_step(inst, exp_wen, exp_rd, exp_data, exp_npc);
        check_val("wb valid", 64'(wb.valid), 64'(exp_wen));
        if (exp_wen) begin
          check_val("wb rd", 64'(wb.rd), 64'(exp_rd));
          check_val("wb data", wb.data, exp_data);
          sregs[exp_rd] = exp_data;
        end
        spc = exp_npc;
      end
      prev_stall = stall;
      @(negedge clk);
    end
    inst_valid = 1'b0;
    #1;
    check_val("final pc", pc, spc);
    $display("SIMULATION PASSED");
    $finish;
  end

endmodule

`default_nettype wire

// File: list.f
+incdir+common
common/rv_pkg.sv
design/if_stage.sv
design/id_stage.sv
design/regfile.sv
exu/exe_stage.sv
design/rv_core.sv
verif/rv_core_sva.sv
verif/tb_rv_core.sv
